// ==== include/aluDemoSettings_settings.svh ====
// Build-time sizes for the ALU demonstrator, shared by RTL and testbench
// ALU_WIDTH must equal four bits per digit times DIGIT_COUNT
// DIGIT_COUNT should be a power of two so the pointer wraps cleanly
// SYNC_STAGES must be at least 2
`ifndef ALU_DEMO_SETTINGS_SVH
`define ALU_DEMO_SETTINGS_SVH

// Operand and result width in bits
`define ALU_WIDTH 16

// Number of hex digits entered per operand
`define DIGIT_COUNT 4

// Flip-flops in each key synchronizer
`define SYNC_STAGES 2

`endif

// ==== src/aluDemoPkg.sv ====
// Shared types for the ALU demonstrator
// Encodings match the switch fields sw[6:4] and sw[9:8] directly
`default_nettype none

package aluDemoPkg;

	// Operation select from sw[6:4]
	typedef enum logic [2:0] {
		opAdd = 3'd0,
		opSub = 3'd1,
		opAnd = 3'd2,
		opOr  = 3'd3,
		opXor = 3'd4,
		// Signed compare, result is 1 when A < B
		opSlt = 3'd5,
		// Shift A left by B[3:0]
		opShl = 3'd6,
		// Logical shift A right by B[3:0]
		opShr = 3'd7
	} aluOp;

	// Entry and display mode from sw[9:8]
	typedef enum logic [1:0] {
		modeEditA = 2'd0,
		modeEditB = 2'd1,
		modeShowResult = 2'd2,
		// Same behavior as modeShowResult
		modeShowResultAlt = 2'd3
	} entryMode;

endpackage

`default_nettype wire

// ==== src/pressDetect.sv ====
// One-shot press detector for an active-low push button
// No debounce filter, so the key is assumed to be clean after synchronizing
// Pulse appears at the third clk edge after the key goes low
`default_nettype none
`timescale 1ns/1ps
`include "aluDemoSettings_settings.svh"

module pressDetect (
	input  logic clk,
	input  logic arstN,
	input  logic keyN,
	output logic pulse
);

	// Synchronizer chain on the inverted key, last stage is the clean level
	logic [`SYNC_STAGES-1:0] syncQ;
	// Level seen one cycle earlier
	logic pressedPrev;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			syncQ <= '0;
			pressedPrev <= 1'b0;
			pulse <= 1'b0;
		end else begin
			// Shift in the active-high press level
			syncQ <= {syncQ[`SYNC_STAGES-2:0], ~keyN};
			pressedPrev <= syncQ[`SYNC_STAGES-1];
			// Rising edge of the synchronized press
			pulse <= syncQ[`SYNC_STAGES-1] & ~pressedPrev;
		end
	end

endmodule

`default_nettype wire

// ==== src/operandEntry.sv ====
// Decode stage for operand entry, one hex nibble per enter press
// Digits load least significant first and the pointer wraps after the top digit
// Result modes hold the pointer at zero and ignore enter
`default_nettype none
`timescale 1ns/1ps
`include "aluDemoSettings_settings.svh"

module operandEntry (
	input  logic                             clk,
	input  logic                             arstN,
	input  aluDemoPkg::entryMode             mode,
	input  logic [3:0]                       nibble,
	input  logic                             enterPulse,
	output logic [`ALU_WIDTH-1:0]            opA,
	output logic [`ALU_WIDTH-1:0]            opB,
	output logic [$clog2(`DIGIT_COUNT)-1:0]  digitSel
);

	// Pointer width and last digit index
	localparam int selWidth = $clog2(`DIGIT_COUNT);
	localparam int nibbleWidth = 4;
	localparam logic [selWidth-1:0] lastDigit = selWidth'(`DIGIT_COUNT - 1);

	// Next pointer value with wrap back to digit 0
	logic [selWidth-1:0] digitNext;

	always_comb begin
		if (digitSel == lastDigit) begin
			digitNext = '0;
		end else begin
			digitNext = digitSel + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opA <= '0;
			opB <= '0;
			digitSel <= '0;
		end else begin
			case (mode)
				aluDemoPkg::modeEditA: begin
					// Write the pointed digit of A, then step
					if (enterPulse) begin
						opA[digitSel*nibbleWidth +: nibbleWidth] <= nibble;
						digitSel <= digitNext;
					end
				end
				aluDemoPkg::modeEditB: begin
					// Same for B, A keeps its value
					if (enterPulse) begin
						opB[digitSel*nibbleWidth +: nibbleWidth] <= nibble;
						digitSel <= digitNext;
					end
				end
				default: begin
					// Either result mode restarts entry at digit 0
					digitSel <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
// Execute stage, purely combinational
// Add, subtract and set-less-than share one adder
// Shift amount is B[3:0], so shifts beyond 15 are not reachable
// Carry and overflow are only meaningful for add and subtract
`default_nettype none
`timescale 1ns/1ps
`include "aluDemoSettings_settings.svh"

module alu (
	input  logic [`ALU_WIDTH-1:0] a,
	input  logic [`ALU_WIDTH-1:0] b,
	input  aluDemoPkg::aluOp      op,
	output logic [`ALU_WIDTH-1:0] result,
	output logic                  carry,
	output logic                  negative,
	output logic                  overflow,
	output logic                  zero
);

	localparam int msb = `ALU_WIDTH - 1;

	// Subtract and compare both take A + ~B + 1
	logic subtracting;
	logic arith;
	logic [`ALU_WIDTH-1:0] addB;
	// One extra bit holds the carry out
	logic [`ALU_WIDTH:0] sum;
	logic addOverflow;
	logic lessThan;
	logic [3:0] shamt;

	assign subtracting = (op == aluDemoPkg::opSub) || (op == aluDemoPkg::opSlt);
	assign arith = (op == aluDemoPkg::opAdd) || (op == aluDemoPkg::opSub);
	assign addB = subtracting ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, addB} + {{`ALU_WIDTH{1'b0}}, subtracting};

	// Signed overflow when both adder inputs agree in sign and the sum does not
	assign addOverflow = (a[msb] == addB[msb]) && (sum[msb] != a[msb]);

	// Signed A < B from the difference sign, corrected by overflow
	assign lessThan = sum[msb] ^ addOverflow;

	assign shamt = b[3:0];

	always_comb begin
		case (op)
			aluDemoPkg::opAdd: result = sum[msb:0];
			aluDemoPkg::opSub: result = sum[msb:0];
			aluDemoPkg::opAnd: result = a & b;
			aluDemoPkg::opOr: result = a | b;
			aluDemoPkg::opXor: result = a ^ b;
			aluDemoPkg::opSlt: result = {{(`ALU_WIDTH-1){1'b0}}, lessThan};
			aluDemoPkg::opShl: result = a << shamt;
			aluDemoPkg::opShr: result = a >> shamt;
			default: result = '0;
		endcase
	end

	// Carry out of the adder, which for subtract means A >= B unsigned
	assign carry = arith ? sum[`ALU_WIDTH] : 1'b0;
	assign overflow = arith ? addOverflow : 1'b0;

	// Result-based flags for every operation
	assign negative = result[msb];
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== src/resultCapture.sv ====
// Result stage, latches the ALU output and flags on each run press
// The display word is registered, so it trails the selected source by one edge
// flagLeds order is carry, negative, overflow, zero from bit 3 down
`default_nettype none
`timescale 1ns/1ps
`include "aluDemoSettings_settings.svh"

module resultCapture (
	input  logic                  clk,
	input  logic                  arstN,
	input  aluDemoPkg::entryMode  mode,
	input  logic                  runPulse,
	input  logic [`ALU_WIDTH-1:0] opA,
	input  logic [`ALU_WIDTH-1:0] opB,
	input  logic [`ALU_WIDTH-1:0] result,
	input  logic                  carry,
	input  logic                  negative,
	input  logic                  overflow,
	input  logic                  zero,
	output logic [`ALU_WIDTH-1:0] displayWord,
	output logic [3:0]            flagLeds
);

	// Last captured ALU result
	logic [`ALU_WIDTH-1:0] heldResult;

	// Capture only on run, hold otherwise
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			heldResult <= '0;
			flagLeds <= '0;
		end else if (runPulse) begin
			heldResult <= result;
			flagLeds <= {carry, negative, overflow, zero};
		end
	end

	// Pick what the four digits show
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			displayWord <= '0;
		end else begin
			case (mode)
				aluDemoPkg::modeEditA: displayWord <= opA;
				aluDemoPkg::modeEditB: displayWord <= opB;
				default: displayWord <= heldResult;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/hexDecoder.sv ====
// Hex digit to seven-segment pattern, active low for common-anode displays
// Bit 0 drives segment a and bit 6 drives segment g
`default_nettype none
`timescale 1ns/1ps

module hexDecoder (
	input  logic [3:0] digit,
	output logic [6:0] segments
);

	always_comb begin
		case (digit)
			4'h0: segments = 7'h40;
			4'h1: segments = 7'h79;
			4'h2: segments = 7'h24;
			4'h3: segments = 7'h30;
			4'h4: segments = 7'h19;
			4'h5: segments = 7'h12;
			4'h6: segments = 7'h02;
			4'h7: segments = 7'h78;
			4'h8: segments = 7'h00;
			4'h9: segments = 7'h10;
			// Letters A to F, with b and d in lower case
			4'hA: segments = 7'h08;
			4'hB: segments = 7'h03;
			4'hC: segments = 7'h46;
			4'hD: segments = 7'h21;
			4'hE: segments = 7'h06;
			4'hF: segments = 7'h0E;
			default: segments = 7'h7F;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/aluDemo.sv ====
// Board top for the 16-bit ALU demonstrator, everything on clk
// sw[3:0] nibble, sw[6:4] operation, sw[9:8] mode, sw[7] has no function
// key[0] is enter and key[1] is run, both active low
`default_nettype none
`timescale 1ns/1ps
`include "aluDemoSettings_settings.svh"

module aluDemo (
	input  logic       clk,
	input  logic       arstN,
	input  logic [9:0] sw,
	input  logic [1:0] key,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex5,
	output logic [3:0] flagLeds
);

	// Switch fields
	aluDemoPkg::aluOp op;
	aluDemoPkg::entryMode mode;

	logic enterPulse;
	logic runPulse;
	logic [`ALU_WIDTH-1:0] opA;
	logic [`ALU_WIDTH-1:0] opB;
	logic [$clog2(`DIGIT_COUNT)-1:0] digitSel;
	logic [`ALU_WIDTH-1:0] result;
	logic carry;
	logic negative;
	logic overflow;
	logic zero;
	logic [`ALU_WIDTH-1:0] displayWord;

	assign op = aluDemoPkg::aluOp'(sw[6:4]);
	assign mode = aluDemoPkg::entryMode'(sw[9:8]);

	// Key edge pulses
	pressDetect u_enterPress (.clk(clk), .arstN(arstN), .keyN(key[0]), .pulse(enterPulse));
	pressDetect u_runPress (.clk(clk), .arstN(arstN), .keyN(key[1]), .pulse(runPulse));

	// Decode
	operandEntry u_operandEntry (
		.clk(clk), .arstN(arstN), .mode(mode), .nibble(sw[3:0]),
		.enterPulse(enterPulse), .opA(opA), .opB(opB), .digitSel(digitSel)
	);

	// Execute
	alu u_alu (
		.a(opA), .b(opB), .op(op), .result(result),
		.carry(carry), .negative(negative), .overflow(overflow), .zero(zero)
	);

	// Result capture and display select
	resultCapture u_resultCapture (
		.clk(clk), .arstN(arstN), .mode(mode), .runPulse(runPulse),
		.opA(opA), .opB(opB), .result(result),
		.carry(carry), .negative(negative), .overflow(overflow), .zero(zero),
		.displayWord(displayWord), .flagLeds(flagLeds)
	);

	// Four data digits, most significant on hex3
	hexDecoder u_hex0 (.digit(displayWord[3:0]), .segments(hex0));
	hexDecoder u_hex1 (.digit(displayWord[7:4]), .segments(hex1));
	hexDecoder u_hex2 (.digit(displayWord[11:8]), .segments(hex2));
	hexDecoder u_hex3 (.digit(displayWord[15:12]), .segments(hex3));

	// Digit pointer, zero-extended to a nibble
	hexDecoder u_hex5 (.digit(4'(digitSel)), .segments(hex5));

endmodule

`default_nettype wire

// ==== bench/aluDemoTb.sv ====
// Directed testbench for the ALU demonstrator top level
// Expected values come from a bench model of the ALU and a bench segment table
// Random operands assume ALU_WIDTH of at most 32 bits
`default_nettype none
`timescale 1ns/1ps
`include "aluDemoSettings_settings.svh"

module aluDemoTb;

	localparam int selWidth = $clog2(`DIGIT_COUNT);
	// Cycle budget per action as spent by the task bodies below
	localparam int pressLen = 11;
	localparam int nibbleLen = 1 + pressLen;
	localparam int modeLen = 11;
	localparam int operandLen = modeLen + `DIGIT_COUNT * nibbleLen;
	localparam int runLen = modeLen + pressLen;
	localparam int caseLen = 2 * operandLen + runLen + modeLen + 1;
	localparam int test2Len = operandLen + nibbleLen + 16;
	localparam int test3Len = operandLen + 4 * modeLen + 2 * nibbleLen + 3;
	localparam int test4Len = 11 * caseLen;
	localparam int test5Len = operandLen + 2 * modeLen + runLen + 2;
	localparam int cycleLimit = 2 * (4 + 1 + test2Len + test3Len + test4Len + test5Len);

	logic clk;
	logic arstN;
	logic [9:0] sw;
	logic [1:0] key;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex5;
	logic [3:0] flagLeds;

	// Shadow state of the expected DUT contents
	logic [`ALU_WIDTH-1:0] expA;
	logic [`ALU_WIDTH-1:0] expB;
	logic [`ALU_WIDTH-1:0] expHeld;
	logic [3:0] expFlags;
	logic [selWidth-1:0] expSel;
	aluDemoPkg::entryMode curMode;
	logic [31:0] rngState;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int cycleCount = 0;

	aluDemo u_dut (
		.clk(clk), .arstN(arstN), .sw(sw), .key(key),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex5(hex5),
		.flagLeds(flagLeds)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	// Active-low patterns with bit 0 as segment a
	function automatic logic [6:0] segmentsFor(input int value);
		case (value)
			0: return 7'h40;
			1: return 7'h79;
			2: return 7'h24;
			3: return 7'h30;
			4: return 7'h19;
			5: return 7'h12;
			6: return 7'h02;
			7: return 7'h78;
			8: return 7'h00;
			9: return 7'h10;
			10: return 7'h08;
			11: return 7'h03;
			12: return 7'h46;
			13: return 7'h21;
			14: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	// Pattern back to a digit or -1 when nothing matches
	function automatic int nibbleOf(input logic [6:0] segs);
		for (int i = 0; i < 16; i++) begin
			if (segmentsFor(i) == segs) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [`ALU_WIDTH-1:0] nextOperand();
		rngState = xorshift32(rngState);
		return `ALU_WIDTH'(rngState);
	endfunction

	// Carry, negative, overflow and zero sit above the result bits
	function automatic logic [`ALU_WIDTH+3:0] modelAlu(input logic [`ALU_WIDTH-1:0] a,
			input logic [`ALU_WIDTH-1:0] b, input aluDemoPkg::aluOp op);
		longint sa;
		longint sb;
		longint sres;
		longint maxS;
		longint minS;
		logic [`ALU_WIDTH-1:0] res;
		logic c;
		logic v;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		maxS = (longint'(1) <<< (`ALU_WIDTH - 1)) - 1;
		minS = -(longint'(1) <<< (`ALU_WIDTH - 1));
		sres = 0;
		c = 1'b0;
		res = '0;
		case (op)
			aluDemoPkg::opAdd: begin
				res = a + b;
				sres = sa + sb;
				c = (longint'(a) + longint'(b)) >= (longint'(1) <<< `ALU_WIDTH);
			end
			aluDemoPkg::opSub: begin
				res = a - b;
				sres = sa - sb;
				// Set when no borrow
				c = (a >= b);
			end
			aluDemoPkg::opAnd: res = a & b;
			aluDemoPkg::opOr: res = a | b;
			aluDemoPkg::opXor: res = a ^ b;
			aluDemoPkg::opSlt: res = (sa < sb) ? `ALU_WIDTH'(1) : '0;
			aluDemoPkg::opShl: res = a << b[3:0];
			default: res = a >> b[3:0];
		endcase
		v = (sres > maxS) || (sres < minS);
		return {c, res[`ALU_WIDTH-1], v, (res == '0), res};
	endfunction

	task automatic checkWord(input logic [`ALU_WIDTH-1:0] expected);
		logic [6:0] segs [4];
		logic [`ALU_WIDTH-1:0] shown;
		int n;
		segs[0] = hex0;
		segs[1] = hex1;
		segs[2] = hex2;
		segs[3] = hex3;
		shown = '0;
		for (int i = 0; i < `DIGIT_COUNT; i++) begin
			n = nibbleOf(segs[i]);
			if (n < 0) begin
				$display("At %0t a data digit shows a pattern that is no hex digit", $time);
				errorCount++;
				return;
			end
			shown[i*4 +: 4] = 4'(n);
		end
		if (shown !== expected) begin
			$display("Error at %0t: hex3..hex0 expected %h, got %h", $time, expected, shown);
			errorCount++;
		end
	endtask

	task automatic checkFlags(input logic [3:0] expected);
		if (flagLeds !== expected) begin
			$display("Error at %0t: flagLeds expected %b, got %b", $time, expected, flagLeds);
			errorCount++;
		end
	endtask

	task automatic checkDigit(input logic [selWidth-1:0] expected);
		int n;
		n = nibbleOf(hex5);
		if (n < 0) begin
			$display("At %0t hex5 shows a pattern that is no hex digit", $time);
			errorCount++;
		end else if (n != int'(expected)) begin
			$display("Error at %0t: hex5 expected %0d, got %0d", $time, expected, n);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			testsPassed++;
			$display("%s: ok", name);
		end else begin
			testsFailed++;
			$display("%s: failed", name);
		end
	endtask

	// Key low for hold cycles and then released for six
	task automatic pressKey(input logic keyIndex, input int hold);
		@(posedge clk);
		key[keyIndex] <= 1'b0;
		repeat (hold) @(posedge clk);
		key[keyIndex] <= 1'b1;
		repeat (6) @(posedge clk);
	endtask

	task automatic setMode(input aluDemoPkg::entryMode mode);
		@(posedge clk);
		sw[9:8] <= mode;
		curMode = mode;
		if (mode != aluDemoPkg::modeEditA && mode != aluDemoPkg::modeEditB) begin
			expSel = '0;
		end
		repeat (10) @(posedge clk);
	endtask

	task automatic setOp(input aluDemoPkg::aluOp op);
		@(posedge clk);
		sw[6:4] <= op;
		repeat (10) @(posedge clk);
	endtask

	// One enter press in the current edit mode and a check of display and pointer
	task automatic enterNibble(input logic [3:0] nibble, input int hold);
		@(posedge clk);
		sw[3:0] <= nibble;
		pressKey(1'b0, hold);
		if (curMode == aluDemoPkg::modeEditA) begin
			expA[expSel*4 +: 4] = nibble;
		end else begin
			expB[expSel*4 +: 4] = nibble;
		end
		expSel = (expSel == selWidth'(`DIGIT_COUNT - 1)) ? '0 : expSel + 1'b1;
		@(negedge clk);
		checkWord((curMode == aluDemoPkg::modeEditA) ? expA : expB);
		checkDigit(expSel);
	endtask

	task automatic enterOperand(input aluDemoPkg::entryMode mode,
			input logic [`ALU_WIDTH-1:0] value);
		setMode(mode);
		for (int i = 0; i < `DIGIT_COUNT; i++) begin
			enterNibble(value[i*4 +: 4], 4);
		end
	endtask

	task automatic runOp(input aluDemoPkg::aluOp op);
		setOp(op);
		pressKey(1'b1, 4);
		{expFlags, expHeld} = modelAlu(expA, expB, op);
	endtask

	task automatic runCase(input aluDemoPkg::aluOp op, input logic [`ALU_WIDTH-1:0] a,
			input logic [`ALU_WIDTH-1:0] b);
		enterOperand(aluDemoPkg::modeEditA, a);
		enterOperand(aluDemoPkg::modeEditB, b);
		runOp(op);
		setMode(aluDemoPkg::modeShowResult);
		@(negedge clk);
		checkWord(expHeld);
		checkFlags(expFlags);
	endtask

	task automatic testReset();
		int errorsBefore;
		errorsBefore = errorCount;
		@(negedge clk);
		checkWord('0);
		checkDigit('0);
		checkFlags('0);
		reportTest("reset state", errorsBefore);
	endtask

	task automatic testEditA();
		int errorsBefore;
		errorsBefore = errorCount;
		enterOperand(aluDemoPkg::modeEditA, nextOperand());
		// Long hold still loads a single digit
		enterNibble(4'hC, 20);
		reportTest("operand A entry", errorsBefore);
	endtask

	task automatic testEditB();
		int errorsBefore;
		errorsBefore = errorCount;
		// Pointer left at 1 by the previous test
		setMode(aluDemoPkg::modeShowResult);
		@(negedge clk);
		checkDigit('0);
		enterOperand(aluDemoPkg::modeEditB, nextOperand());
		setMode(aluDemoPkg::modeEditA);
		@(negedge clk);
		checkWord(expA);
		setMode(aluDemoPkg::modeEditB);
		enterNibble(4'h5, 4);
		enterNibble(4'hA, 4);
		setMode(aluDemoPkg::modeShowResultAlt);
		@(negedge clk);
		checkDigit('0);
		checkWord(expHeld);
		reportTest("operand B entry", errorsBefore);
	endtask

	task automatic testOperations();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int i = 0; i < 8; i++) begin
			runCase(aluDemoPkg::aluOp'(3'(i)), nextOperand(), nextOperand());
		end
		// Signed overflow, borrow and carry out with zero result
		runCase(aluDemoPkg::opAdd, 16'h7FFF, 16'h0001);
		runCase(aluDemoPkg::opSub, 16'h0000, 16'h0001);
		runCase(aluDemoPkg::opAdd, 16'hFFFF, 16'h0001);
		reportTest("all operations", errorsBefore);
	endtask

	task automatic testHoldResult();
		int errorsBefore;
		errorsBefore = errorCount;
		enterOperand(aluDemoPkg::modeEditA, nextOperand());
		setOp(aluDemoPkg::opOr);
		setMode(aluDemoPkg::modeShowResult);
		@(negedge clk);
		checkWord(expHeld);
		checkFlags(expFlags);
		// Run press now picks up the new A and operation
		runOp(aluDemoPkg::opOr);
		@(negedge clk);
		checkWord(expHeld);
		checkFlags(expFlags);
		reportTest("result hold until run", errorsBefore);
	endtask

	initial begin
		sw <= '0;
		key <= 2'b11;
		arstN <= 1'b0;
		rngState = 32'd13;
		expA = '0;
		expB = '0;
		expHeld = '0;
		expFlags = '0;
		expSel = '0;
		curMode = aluDemoPkg::modeEditA;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		testReset();
		testEditA();
		testEditB();
		testOperations();
		testHoldResult();
		$display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
src/aluDemoPkg.sv
src/pressDetect.sv
src/operandEntry.sv
src/alu.sv
src/resultCapture.sv
src/hexDecoder.sv
src/aluDemo.sv
bench/aluDemoTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU demonstrator testbench with Verilator
# Exit status is 0 only when the simulation reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module aluDemoTb -Mdir obj_dir -o aluDemoSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/aluDemoSim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
